/* run_sim.sh */
#!/bin/sh
# Build and run the radio core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal --timescale 1ns/1ps \
   -f src.f --top-module radio_core_tb -o radio_core_sim

out=$(./obj_dir/radio_core_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
   exit 0
fi
exit 1

/* src.f */
+incdir+verilog
verilog/radio_regs_pkg.sv
verilog/radio_stream_pkg.sv
verilog/radio_time_counter.sv
verilog/radio_rx_framer.sv
verilog/radio_tx_scaler.sv
verilog/radio_ctrl.sv
verilog/radio_core_top.sv
verif/radio_core_tb.sv

/* verif/radio_core_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Radio core testbench
// Table of register, receive and transmit steps checked by stream monitors
////////////////////////////////////////////////////////////////////////////
`include "radio_settings.svh"

module radio_core_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import radio_regs_pkg::*;
   import radio_stream_pkg::*;

   typedef enum {OP_WRITE, OP_READ, OP_RX, OP_STALL, OP_TX} op_e;

   // RX and STALL steps carry the burst in data and the beat count in expected
   // TX steps carry the sample count in data and the gap position in addr
   typedef struct {
      string     name;
      op_e       op;
      set_addr_t addr;
      set_data_t data;
      rb_data_t  expected;
   } step_t;

   localparam int NUM_STEPS   = 32;
   localparam int STEP_CYCLES = 125;
   localparam int TIMEOUT     = NUM_STEPS * STEP_CYCLES;

   logic          clk;
   logic          reset;
   settings_bus_t set_bus;
   rb_data_t      rb_data;
   sample_t       rx_sample = '0;
   rx_beat_t      rx_beat;
   logic          rx_tvalid;
   logic          rx_tready;
   tx_beat_t      tx_beat;
   logic          tx_tvalid;
   logic          tx_tready;
   sample_t       tx_out;

   step_t       steps[NUM_STEPS];
   int          num_added = 0;
   rx_beat_t    rx_q[$];
   sample_t     tx_q[$];
   sample_t     tx_exp_q[$];
   logic        tx_acc_prev = 1'b0;
   int          cycle = 0;
   int          errors = 0;
   int          checks = 0;
   logic [31:0] lcg_state = 32'h485c;
   pkt_len_t    pkt_len_exp = 12'd4;
   tx_scale_t   scale_exp = 16'd16384;
   set_data_t   time_hi_exp = '0;

   radio_core_top i_dut (
      .ce_clk      (clk),
      .i_reset     (reset),
      .i_set       (set_bus),
      .o_rb_data   (rb_data),
      .i_rx        (rx_sample),
      .o_rx_beat   (rx_beat),
      .o_rx_tvalid (rx_tvalid),
      .i_rx_tready (rx_tready),
      .i_tx_beat   (tx_beat),
      .i_tx_tvalid (tx_tvalid),
      .o_tx_tready (tx_tready),
      .o_tx        (tx_out)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Cycle count and watchdog
   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle >= TIMEOUT) begin
         $display("Timeout after %0d cycles, the test did not finish", cycle);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // ADC ramp from the cycle count
   always @(negedge clk) begin
      rx_sample <= sample_t'(cycle);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stream monitors
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      if (!reset && rx_tvalid && rx_tready) begin
         rx_q.push_back(rx_beat);
      end
   end

   // DAC shows an accepted beat one cycle later and zero otherwise
   always @(posedge clk) begin
      if (!reset) begin
         if (tx_acc_prev) begin
            tx_q.push_back(tx_out);
         end else begin
            assert (tx_out === '0) else begin
               errors++;
               $display("[FAIL] tx_idle: expected 0, actual %0h", tx_out);
            end
         end
      end
      tx_acc_prev = tx_tvalid && tx_tready;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Signed product, arithmetic shift by 14, clip to 16 bits
   function automatic logic [15:0] gain_component(logic [15:0] x, logic [15:0] g);
      int p;
      p = int'($signed(x)) * int'($signed(g));
      p = p >>> 14;
      if (p > 32767) begin
         p = 32767;
      end else if (p < -32768) begin
         p = -32768;
      end
      return p[15:0];
   endfunction

   task automatic add_step(string name, op_e op, set_addr_t addr, set_data_t data,
                           rb_data_t expected);
      steps[num_added] = '{name, op, addr, data, expected};
      num_added++;
   endtask

   task automatic check_value(string name, rb_data_t exp, rb_data_t act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   // One strobe cycle and a register model update
   task automatic write_reg(set_addr_t addr, set_data_t data);
      @(negedge clk);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge clk);
      set_bus.stb = 1'b0;
      if (addr == `SR_PKT_LEN && data[11:0] != 12'd0) begin
         pkt_len_exp = data[11:0];
      end
      if (addr == `SR_TX_SCALE) begin
         scale_exp = data[15:0];
      end
      if (addr == `SR_TIME_HI) begin
         time_hi_exp = data;
      end
   endtask

   task automatic read_check(string name, set_data_t sel, rb_data_t exp);
      write_reg(`SR_READBACK, sel);
      @(negedge clk);
      check_value(name, exp, rb_data);
   endtask

   task automatic wait_rx_idle();
      while (rb_data[2] !== 1'b0) begin
         @(negedge clk);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Receive checks
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_rx_frames(string name, int n, int beats, sample_t first_sample);
      rb_data_t first_off;
      rb_data_t pkt_tuser;
      int       plen;
      int       i;
      logic     last_exp;
      plen = int'(pkt_len_exp);
      check_value({name, " beats"}, beats, rx_q.size());
      for (i = 0; i < rx_q.size(); i++) begin
         last_exp = ((i % plen) == plen - 1) || (i == n - 1);
         check_value($sformatf("%s beat %0d tlast", name, i), last_exp, rx_q[i].tlast);
         check_value($sformatf("%s beat %0d tdata", name, i), first_sample + sample_t'(i),
                     rx_q[i].tdata);
         if (i % plen == 0) begin
            // Time of the first sample minus its ramp value
            if (i == 0) begin
               first_off = rx_q[i].tuser - rb_data_t'(rx_q[i].tdata);
            end else begin
               check_value($sformatf("%s pkt %0d step", name, i / plen), pkt_tuser + plen,
                           rx_q[i].tuser);
               check_value($sformatf("%s pkt %0d offset", name, i / plen), first_off,
                           rx_q[i].tuser - rb_data_t'(rx_q[i].tdata));
            end
            check_value($sformatf("%s pkt %0d time hi", name, i / plen), time_hi_exp,
                        rx_q[i].tuser[63:32]);
            pkt_tuser = rx_q[i].tuser;
         end else begin
            check_value($sformatf("%s beat %0d tuser", name, i), pkt_tuser, rx_q[i].tuser);
         end
      end
   endtask

   task automatic run_rx_burst(string name, int n, int beats);
      sample_t first_sample;
      write_reg(`SR_READBACK, `RB_STATUS);
      rx_q.delete();
      write_reg(`SR_RX_CMD, n);
      // First capture is the ramp value driven at this falling edge
      first_sample = sample_t'(cycle);
      while (rx_q.size() < beats) begin
         @(negedge clk);
      end
      wait_rx_idle();
      check_rx_frames(name, n, beats, first_sample);
   endtask

   task automatic run_rx_stall(string name, int n, int beats);
      rx_tready = 1'b0;
      write_reg(`SR_READBACK, `RB_STATUS);
      rx_q.delete();
      write_reg(`SR_RX_CMD, n);
      // Sink held off for the whole burst
      repeat (n + 2) @(negedge clk);
      rx_tready = 1'b1;
      wait_rx_idle();
      check_value({name, " beats"}, beats, rx_q.size());
   endtask

   task automatic run_tx_burst(string name, int n, int gap);
      sample_t s;
      int      i;
      tx_q.delete();
      tx_exp_q.delete();
      for (i = 0; i < n; i++) begin
         @(negedge clk);
         if (gap != 0 && i == gap) begin
            tx_tvalid = 1'b0;
            @(negedge clk);
         end
         s             = next_random();
         tx_beat.tdata = s;
         tx_beat.tlast = (i == n - 1);
         tx_tvalid     = 1'b1;
         tx_exp_q.push_back({gain_component(s[31:16], scale_exp),
                             gain_component(s[15:0], scale_exp)});
      end
      @(negedge clk);
      tx_tvalid = 1'b0;
      while (tx_q.size() < n) begin
         @(negedge clk);
      end
      for (i = 0; i < n; i++) begin
         check_value($sformatf("%s sample %0d", name, i), tx_exp_q[i], tx_q[i]);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Step table and main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      int k;
      reset     = 1'b1;
      set_bus   = '0;
      rx_tready = 1'b1;
      tx_beat   = '0;
      tx_tvalid = 1'b0;

      add_step("rst_status",      OP_READ,  `RB_STATUS,     0,     0);
      add_step("rst_pkt_len",     OP_READ,  `RB_PKT_LEN,    0,     4);
      add_step("rst_tx_scale",    OP_READ,  `RB_TX_SCALE,   0,     16384);
      add_step("wr_pkt_len",      OP_WRITE, `SR_PKT_LEN,    6,     0);
      add_step("rb_pkt_len",      OP_READ,  `RB_PKT_LEN,    0,     6);
      add_step("wr_pkt_len_zero", OP_WRITE, `SR_PKT_LEN,    0,     0);
      add_step("rb_pkt_len_kept", OP_READ,  `RB_PKT_LEN,    0,     6);
      add_step("wr_tx_scale",     OP_WRITE, `SR_TX_SCALE,   8192,  0);
      add_step("rb_tx_scale",     OP_READ,  `RB_TX_SCALE,   0,     8192);
      add_step("wr_pkt_len_4",    OP_WRITE, `SR_PKT_LEN,    4,     0);
      add_step("wr_time_hi",      OP_WRITE, `SR_TIME_HI,    'h1234, 0);
      add_step("wr_time_lo",      OP_WRITE, `SR_TIME_LO,    'h100, 0);
      add_step("rx_burst_10",     OP_RX,    0,              10,    10);
      add_step("rx_busy_clear",   OP_READ,  `RB_STATUS,     0,     0);
      add_step("rx_stall",        OP_STALL, 0,              6,     1);
      add_step("overflow_set",    OP_READ,  `RB_STATUS,     0,     1);
      add_step("rx_clean",        OP_RX,    0,              5,     5);
      add_step("overflow_sticky", OP_READ,  `RB_STATUS,     0,     1);
      add_step("clr_status",      OP_WRITE, `SR_STATUS_CLR, 0,     0);
      add_step("overflow_clear",  OP_READ,  `RB_STATUS,     0,     0);
      add_step("wr_scale_unity",  OP_WRITE, `SR_TX_SCALE,   16384, 0);
      add_step("tx_unity",        OP_TX,    0,              8,     0);
      add_step("wr_scale_half",   OP_WRITE, `SR_TX_SCALE,   8192,  0);
      add_step("tx_half",         OP_TX,    0,              8,     0);
      add_step("wr_scale_max",    OP_WRITE, `SR_TX_SCALE,   32767, 0);
      add_step("rb_scale_max",    OP_READ,  `RB_TX_SCALE,   0,     32767);
      add_step("tx_max",          OP_TX,    0,              8,     0);
      add_step("no_underrun",     OP_READ,  `RB_STATUS,     0,     0);
      add_step("tx_gap",          OP_TX,    3,              8,     0);
      add_step("underrun_set",    OP_READ,  `RB_STATUS,     0,     2);
      add_step("clr_status_2",    OP_WRITE, `SR_STATUS_CLR, 0,     0);
      add_step("underrun_clear",  OP_READ,  `RB_STATUS,     0,     0);

      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (k = 0; k < num_added; k++) begin
         case (steps[k].op)
            OP_WRITE: write_reg(steps[k].addr, steps[k].data);
            OP_READ:  read_check(steps[k].name, steps[k].addr, steps[k].expected);
            OP_RX:    run_rx_burst(steps[k].name, steps[k].data, int'(steps[k].expected));
            OP_STALL: run_rx_stall(steps[k].name, steps[k].data, int'(steps[k].expected));
            OP_TX:    run_tx_burst(steps[k].name, steps[k].data, steps[k].addr);
            default:  ;
         endcase
      end

      repeat (4) @(negedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* verilog/radio_core_top.sv */
////////////////////////////////////////////////////////////////////////////
// Radio core top
// Control block with time counter, receive framer and transmit scaler
////////////////////////////////////////////////////////////////////////////

module radio_core_top (
   input  logic                           ce_clk,
   input  logic                           i_reset,
   input  radio_regs_pkg::settings_bus_t  i_set,
   output radio_regs_pkg::rb_data_t       o_rb_data,
   input  radio_stream_pkg::sample_t      i_rx,
   output radio_stream_pkg::rx_beat_t     o_rx_beat,
   output logic                           o_rx_tvalid,
   input  logic                           i_rx_tready,
   input  radio_stream_pkg::tx_beat_t     i_tx_beat,
   input  logic                           i_tx_tvalid,
   output logic                           o_tx_tready,
   output radio_stream_pkg::sample_t      o_tx
);
   import radio_regs_pkg::*;
   import radio_stream_pkg::*;

   time_load_t time_load;
   timestamp_t time_now;
   pkt_len_t   pkt_len;
   tx_scale_t  tx_scale;
   logic       rx_run;
   logic       rx_final;
   logic       rx_take;
   logic       rx_overflow;
   logic       rx_out_empty;
   logic       tx_underrun;

   radio_ctrl u_ctrl (
      .ce_clk         (ce_clk),
      .i_reset        (i_reset),
      .i_set          (i_set),
      .o_rb_data      (o_rb_data),
      .o_time_load    (time_load),
      .i_time_now     (time_now),
      .o_pkt_len      (pkt_len),
      .o_rx_run       (rx_run),
      .o_rx_final     (rx_final),
      .i_rx_take      (rx_take),
      .i_rx_overflow  (rx_overflow),
      .i_rx_out_empty (rx_out_empty),
      .o_tx_scale     (tx_scale),
      .i_tx_underrun  (tx_underrun)
   );

   radio_time_counter u_time (
      .ce_clk  (ce_clk),
      .i_reset (i_reset),
      .i_load  (time_load),
      .o_time  (time_now)
   );

   // Receive path
   radio_rx_framer u_rx (
      .ce_clk      (ce_clk),
      .i_reset     (i_reset),
      .i_rx        (i_rx),
      .i_time      (time_now),
      .i_run       (rx_run),
      .i_final     (rx_final),
      .i_pkt_len   (pkt_len),
      .o_take      (rx_take),
      .o_overflow  (rx_overflow),
      .o_out_empty (rx_out_empty),
      .o_beat      (o_rx_beat),
      .o_tvalid    (o_rx_tvalid),
      .i_tready    (i_rx_tready)
   );

   // Transmit path
   radio_tx_scaler u_tx (
      .ce_clk     (ce_clk),
      .i_reset    (i_reset),
      .i_beat     (i_tx_beat),
      .i_tvalid   (i_tx_tvalid),
      .o_tready   (o_tx_tready),
      .i_scale    (tx_scale),
      .o_tx       (o_tx),
      .o_underrun (tx_underrun)
   );

endmodule

/* verilog/radio_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Radio control
// Settings decode, readback mux, sticky status and receive burst FSM
////////////////////////////////////////////////////////////////////////////
`include "radio_settings.svh"

module radio_ctrl (
   input  logic                           ce_clk,
   input  logic                           i_reset,
   input  radio_regs_pkg::settings_bus_t  i_set,
   output radio_regs_pkg::rb_data_t       o_rb_data,
   output radio_regs_pkg::time_load_t     o_time_load,
   input  radio_stream_pkg::timestamp_t   i_time_now,
   output radio_regs_pkg::pkt_len_t       o_pkt_len,
   output logic                           o_rx_run,
   output logic                           o_rx_final,
   input  logic                           i_rx_take,
   input  logic                           i_rx_overflow,
   input  logic                           i_rx_out_empty,
   output radio_regs_pkg::tx_scale_t      o_tx_scale,
   input  logic                           i_tx_underrun
);
   import radio_regs_pkg::*;

   rx_state_e  state;
   burst_len_t remaining;
   pkt_len_t   pkt_len;
   tx_scale_t  tx_scale;
   set_data_t  time_hi;
   logic [1:0] rb_sel;
   logic       overflow_flag;
   logic       underrun_flag;
   logic       wr_rx_cmd;
   logic       wr_clr;
   rb_data_t   status_word;

   assign wr_rx_cmd = i_set.stb && (i_set.addr == `SR_RX_CMD) && (i_set.data != '0);
   assign wr_clr    = i_set.stb && (i_set.addr == `SR_STATUS_CLR);

   // Low word write commits the staged high word with it
   assign o_time_load.load  = i_set.stb && (i_set.addr == `SR_TIME_LO);
   assign o_time_load.value = {time_hi, i_set.data};

   assign o_pkt_len  = pkt_len;
   assign o_tx_scale = tx_scale;
   assign o_rx_run   = (state == RUN);
   assign o_rx_final = (remaining == burst_len_t'(1));

   ////////////////////////////////////////////////////////////////////////////
   // Settings registers
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         pkt_len  <= `RADIO_PKT_LEN_RST;
         tx_scale <= `RADIO_TX_SCALE_RST;
         time_hi  <= '0;
         rb_sel   <= `RB_STATUS;
      end else if (i_set.stb) begin
         case (i_set.addr)
            `SR_PKT_LEN: begin
               // Zero length would never close a packet
               if (i_set.data[`RADIO_PKT_LEN_W-1:0] != '0) begin
                  pkt_len <= i_set.data[`RADIO_PKT_LEN_W-1:0];
               end
            end
            `SR_TX_SCALE: tx_scale <= i_set.data[15:0];
            `SR_TIME_HI:  time_hi  <= i_set.data;
            `SR_READBACK: rb_sel   <= i_set.data[1:0];
            default: ;
         endcase
      end
   end

   // Sticky flags where a new event wins over a clear in the same cycle
   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         overflow_flag <= 1'b0;
         underrun_flag <= 1'b0;
      end else begin
         if (wr_clr) begin
            overflow_flag <= 1'b0;
            underrun_flag <= 1'b0;
         end
         if (i_rx_overflow) overflow_flag <= 1'b1;
         if (i_tx_underrun) underrun_flag <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Receive burst FSM
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         state     <= IDLE;
         remaining <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (wr_rx_cmd) begin
                  remaining <= i_set.data;
                  state     <= RUN;
               end
            end
            RUN: begin
               if (i_rx_take) begin
                  remaining <= remaining - 1'b1;
                  if (o_rx_final) state <= DRAIN;
               end
            end
            DRAIN: begin
               // Wait for the last beat to leave the framer
               if (i_rx_out_empty) state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Readback
   assign status_word = {61'd0, (state != IDLE), underrun_flag, overflow_flag};

   always_ff @(posedge ce_clk) begin
      case (rb_sel)
         `RB_STATUS:   o_rb_data <= status_word;
         `RB_PKT_LEN:  o_rb_data <= rb_data_t'(pkt_len);
         `RB_TX_SCALE: o_rb_data <= rb_data_t'(tx_scale);
         `RB_TIME:     o_rb_data <= i_time_now;
      endcase
   end

   // Nothing left in the framer while idle
   a_idle_quiet: assert property (@(posedge ce_clk) disable iff (i_reset)
      (state == IDLE) |-> i_rx_out_empty);

   a_take_in_run: assert property (@(posedge ce_clk) disable iff (i_reset)
      i_rx_take |-> (state == RUN));

endmodule

/* verilog/radio_regs_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Radio register types
// Settings bus, readback, control fields and the receive burst states
////////////////////////////////////////////////////////////////////////////
`include "radio_settings.svh"

package radio_regs_pkg;

   // Settings bus fields
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] rb_data_t;

   // Control fields
   typedef logic [`RADIO_PKT_LEN_W-1:0] pkt_len_t;
   typedef logic [31:0]                 burst_len_t;
   // Q1.14, 16384 is unity
   typedef logic [15:0]                 tx_scale_t;

   // One write per cycle, no acknowledge
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } settings_bus_t;

   // Atomic load of the radio time
   typedef struct packed {
      logic                     load;
      logic [`RADIO_TIME_W-1:0] value;
   } time_load_t;

   // Receive burst machine
   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DRAIN
   } rx_state_e;

endpackage

/* verilog/radio_rx_framer.sv */
////////////////////////////////////////////////////////////////////////////
// Receive framer
// Packs ADC samples into timestamped packets and flags overflow
////////////////////////////////////////////////////////////////////////////

module radio_rx_framer (
   input  logic                          ce_clk,
   input  logic                          i_reset,
   input  radio_stream_pkg::sample_t     i_rx,
   input  radio_stream_pkg::timestamp_t  i_time,
   input  logic                          i_run,
   input  logic                          i_final,
   input  radio_regs_pkg::pkt_len_t      i_pkt_len,
   output logic                          o_take,
   output logic                          o_overflow,
   output logic                          o_out_empty,
   output radio_stream_pkg::rx_beat_t    o_beat,
   output logic                          o_tvalid,
   input  logic                          i_tready
);
   import radio_regs_pkg::*;
   import radio_stream_pkg::*;

   pkt_len_t   count;
   pkt_len_t   count_next;
   timestamp_t first_ts;
   timestamp_t beat_ts;
   rx_beat_t   beat_q;
   logic       valid_q;
   logic       pending;
   logic       capture;
   logic       end_of_pkt;

   // Beat still waiting for the sink, so a new sample is dropped
   assign pending    = valid_q && !i_tready;
   assign capture    = i_run && !pending;
   assign count_next = count + 1'b1;
   assign end_of_pkt = (count_next >= i_pkt_len) || i_final;
   assign beat_ts    = (count == '0) ? i_time : first_ts;

   // Every sample offered in a run is consumed
   assign o_take      = i_run;
   assign o_overflow  = i_run && pending;
   assign o_out_empty = !valid_q;
   assign o_beat      = beat_q;
   assign o_tvalid    = valid_q;

   ////////////////////////////////////////////////////////////////////////////
   // Packet position and output valid
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         valid_q <= 1'b0;
         count   <= '0;
      end else if (capture) begin
         valid_q <= 1'b1;
         count   <= end_of_pkt ? '0 : count_next;
      end else begin
         if (i_tready) valid_q <= 1'b0;
         // Dropped last sample still ends the burst
         if (i_run && i_final) count <= '0;
      end
   end

   // Beat payload and first sample time
   always_ff @(posedge ce_clk) begin
      if (capture) begin
         beat_q.tdata <= i_rx;
         beat_q.tlast <= end_of_pkt;
         beat_q.tuser <= beat_ts;
         if (count == '0) first_ts <= i_time;
      end
   end

   a_hold_beat: assert property (@(posedge ce_clk) disable iff (i_reset)
      (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_beat)));

endmodule

/* verilog/radio_settings.svh */
////////////////////////////////////////////////////////////////////////////
// Radio core settings map
// Register addresses, readback selectors and field widths
////////////////////////////////////////////////////////////////////////////
`ifndef RADIO_SETTINGS_SVH
`define RADIO_SETTINGS_SVH

// Settings bus register addresses
`define RADIO_BASE      8'd128
`define SR_PKT_LEN      (`RADIO_BASE + 8'd0)
`define SR_RX_CMD       (`RADIO_BASE + 8'd1)
`define SR_TX_SCALE     (`RADIO_BASE + 8'd2)
`define SR_TIME_HI      (`RADIO_BASE + 8'd3)
`define SR_TIME_LO      (`RADIO_BASE + 8'd4)
`define SR_STATUS_CLR   (`RADIO_BASE + 8'd5)
`define SR_READBACK     (`RADIO_BASE + 8'd6)

// Readback selector codes
`define RB_STATUS       2'd0
`define RB_PKT_LEN      2'd1
`define RB_TX_SCALE     2'd2
`define RB_TIME         2'd3

// Field widths
`define RADIO_SAMPLE_W  32
`define RADIO_TIME_W    64
`define RADIO_PKT_LEN_W 12

// Values after reset, unity gain is 1.0 in Q1.14
`define RADIO_PKT_LEN_RST   12'd4
`define RADIO_TX_SCALE_RST  16'd16384

`endif

/* verilog/radio_stream_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Radio stream types
// Samples, timestamps and the beats of the receive and transmit streams
////////////////////////////////////////////////////////////////////////////
`include "radio_settings.svh"

package radio_stream_pkg;

   // I in the upper half, Q in the lower half
   typedef logic [`RADIO_SAMPLE_W-1:0] sample_t;
   typedef logic signed [15:0]         iq_t;
   typedef logic [`RADIO_TIME_W-1:0]   timestamp_t;

   // tuser carries the time of the first sample of the packet
   typedef struct packed {
      sample_t    tdata;
      logic       tlast;
      timestamp_t tuser;
   } rx_beat_t;

   typedef struct packed {
      sample_t tdata;
      logic    tlast;
   } tx_beat_t;

endpackage

/* verilog/radio_time_counter.sv */
////////////////////////////////////////////////////////////////////////////
// Radio time counter
// Free-running 64-bit time with an atomic load
////////////////////////////////////////////////////////////////////////////

module radio_time_counter (
   input  logic                          ce_clk,
   input  logic                          i_reset,
   input  radio_regs_pkg::time_load_t    i_load,
   output radio_stream_pkg::timestamp_t  o_time
);
   import radio_stream_pkg::*;

   timestamp_t time_q;

   // Loaded value shows next cycle and counts on from there
   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         time_q <= '0;
      end else if (i_load.load) begin
         time_q <= i_load.value;
      end else begin
         time_q <= time_q + 1'b1;
      end
   end

   assign o_time = time_q;

   a_step_one: assert property (@(posedge ce_clk) disable iff (i_reset)
      !i_load.load |=> (o_time == $past(o_time) + 1'b1));

endmodule

/* verilog/radio_tx_scaler.sv */
////////////////////////////////////////////////////////////////////////////
// Transmit scaler
// Saturating Q1.14 gain on the DAC stream, with underrun detection
////////////////////////////////////////////////////////////////////////////

module radio_tx_scaler (
   input  logic                         ce_clk,
   input  logic                         i_reset,
   input  radio_stream_pkg::tx_beat_t   i_beat,
   input  logic                         i_tvalid,
   output logic                         o_tready,
   input  radio_regs_pkg::tx_scale_t    i_scale,
   output radio_stream_pkg::sample_t    o_tx,
   output logic                         o_underrun
);
   import radio_stream_pkg::*;

   logic ready_q;
   logic accept;
   logic in_burst;

   // Product >>> 14, clipped to the 16-bit range
   function automatic iq_t scale_iq(iq_t x, logic signed [15:0] g);
      logic signed [31:0] prod;
      logic signed [17:0] shifted;
      prod    = x * g;
      shifted = prod[31:14];
      if (shifted > 18'sd32767) begin
         return 16'sh7fff;
      end else if (shifted < -18'sd32768) begin
         return 16'sh8000;
      end
      return shifted[15:0];
   endfunction

   // Output register refills every cycle, so ready after reset
   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= 1'b1;
      end
   end

   assign o_tready = ready_q;
   assign accept   = i_tvalid && ready_q;

   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         o_tx <= '0;
      end else if (accept) begin
         o_tx <= {scale_iq(i_beat.tdata[31:16], i_scale),
                  scale_iq(i_beat.tdata[15:0], i_scale)};
      end else begin
         o_tx <= '0;
      end
   end

   // Inside a burst from a beat without tlast until tlast
   always_ff @(posedge ce_clk) begin
      if (i_reset) begin
         in_burst <= 1'b0;
      end else if (accept) begin
         in_burst <= !i_beat.tlast;
      end
   end

   assign o_underrun = in_burst && !i_tvalid;

   a_no_underrun_after_last: assert property (@(posedge ce_clk) disable iff (i_reset)
      (accept && i_beat.tlast) |=> !o_underrun);

endmodule
